// File: hdd_discovery.f
rtl/hdd_discovery_pkg.sv
rtl/discovery_sequencer.sv
rtl/encoding_classifier.sv
rtl/discovery_results.sv
rtl/discovery_registers.sv
rtl/hdd_discovery.sv
verif/discovery_sequencer_sva.sv
verif/hdd_discovery_tb.sv

// File: Bender.yml
package:
  name: hdd_discovery

sources:
  - rtl/hdd_discovery_pkg.sv
  - rtl/discovery_sequencer.sv
  - rtl/encoding_classifier.sv
  - rtl/discovery_results.sv
  - rtl/discovery_registers.sv
  - rtl/hdd_discovery.sv
  - target: test
    files:
      - verif/discovery_sequencer_sva.sv
      - verif/hdd_discovery_tb.sv

// File: verif/hdd_discovery_tb.sv
`timescale 1ns/1ps

module hdd_discovery_tb;
    import hdd_discovery_pkg::*;

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 8;
    localparam int STAGE_TIMEOUT = 64;

    // One drive as the engines see it
    typedef struct packed {
        phy_report_t      phy;
        rate_report_t     rate;
        decode_counts_t   mfm;      // Counts shown during the MFM trial
        decode_counts_t   rll;      // Counts shown during the RLL trial
        geometry_report_t geom;
        engine_done_t     silent;   // Engines that never answer
        logic             abort;    // Abort written during the PHY wait
    } scenario_t;

    typedef struct packed {
        encoding_t  encoding;
        logic [2:0] rate;
        logic       is_differential;
        geometry_t  geometry;
        logic       valid;
        stage_t     stage;
    } expect_t;

    logic             clk;
    logic             reset;
    reg_bus_t         reg_bus;
    logic [31:0]      rd_data;
    engine_start_t    engine_start;
    engine_done_t     engine_done;
    decode_counts_t   decode_counts;
    scenario_t        scen;           // Scenario now on the engine ports
    scenario_t        tests[$];
    string            names[$];
    int               cur;
    int               errors;
    int               checks;
    bit               run_pending;    // Hand-off to the compare process
    bit               tests_built;

    // Decode engine shows the trial selected by use_mfm
    assign decode_counts = engine_start.use_mfm ? scen.mfm : scen.rll;

    hdd_discovery #(
        .STAGE_TIMEOUT_CYCLES (STAGE_TIMEOUT)
    ) hdd_discovery_inst (
        .clk             (clk),
        .reset           (reset),
        .reg_bus         (reg_bus),
        .rd_data         (rd_data),
        .engine_start    (engine_start),
        .engine_done     (engine_done),
        .phy_report      (scen.phy),
        .rate_report     (scen.rate),
        .decode_counts   (decode_counts),
        .geometry_report (scen.geom)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------------------------------------
    // CPU bus and engine models
    // --------------------------------------------------
    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        #10;
        reg_bus.addr    = addr;
        reg_bus.wr_data = data;
        reg_bus.wr_en   = 1'b1;
        @(posedge clk);
        #10;
        reg_bus.wr_en   = 1'b0;
    endtask

    task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clk);
        #10;
        reg_bus.addr  = addr;
        reg_bus.rd_en = 1'b1;
        @(posedge clk);
        #10;
        reg_bus.rd_en = 1'b0;
        data          = rd_data;   // Registered at the edge just passed
    endtask

    // idx 3 phy, 2 rate, 1 decode, 0 geometry
    task automatic engine_model(input int idx);
        int unsigned delay;
        forever begin
            @(posedge clk);
            #10;
            if (engine_start[idx + 1] && !scen.silent[idx]) begin
                delay = 2 + ($urandom % 19);   // 2 to 20 cycles
                repeat (delay - 1) @(posedge clk);
                #10;
                engine_done[idx] = 1'b1;
                @(posedge clk);
                #10;
                engine_done[idx] = 1'b0;
            end
        end
    endtask

    task automatic add_test(input string name, input phy_report_t phy,
                            input rate_report_t rate, input decode_counts_t mfm,
                            input decode_counts_t rll, input geometry_report_t geom,
                            input engine_done_t silent, input logic abort);
        scenario_t s;
        s.phy    = phy;
        s.rate   = rate;
        s.mfm    = mfm;
        s.rll    = rll;
        s.geom   = geom;
        s.silent = silent;
        s.abort  = abort;
        tests.push_back(s);
        names.push_back(name);
    endtask

    // --------------------------------------------------
    // Expected results from the discovery rules
    // --------------------------------------------------
    function automatic expect_t expected_result(input scenario_t s);
        expect_t e;
        logic    rll_wins;
        e.is_differential = s.phy.is_differential;
        e.rate            = s.rate.valid ? s.rate.rate : DEFAULT_RATE;
        e.geometry        = s.geom.valid ? s.geom.geometry : DEFAULT_GEOMETRY;
        rll_wins = (s.rll.crc_ok > s.mfm.crc_ok) && (s.rll.errors < s.mfm.errors);
        if (e.rate >= ESDI_MIN_RATE || e.is_differential) begin
            e.encoding = ENC_ESDI;
        end else if (rll_wins) begin
            e.encoding = ENC_RLL;
        end else if (s.mfm.crc_ok != 16'd0) begin
            e.encoding = ENC_MFM;
        end else begin
            e.encoding = ENC_UNKNOWN;
        end
        e.valid = s.phy.signal_present && !s.abort;   // Dead link or abort
        e.stage = e.valid ? STAGE_COMPLETE : STAGE_ERROR;
        return e;
    endfunction

    task automatic check_encoding(input string test, input encoding_t exp, input encoding_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s encoding: expected %0d, actual %0d", test, exp, act);
        end
    endtask

    task automatic check_geometry(input string test, input geometry_t exp, input geometry_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s geometry: expected %h, actual %h", test, exp, act);
        end
    endtask

    task automatic check_rate(input string test, input logic [2:0] exp, input logic [2:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s rate: expected %0d, actual %0d", test, exp, act);
        end
    endtask

    task automatic check_stage(input string test, input stage_t exp, input stage_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s stage: expected %0d, actual %0d", test, exp, act);
        end
    endtask

    task automatic check_flag(input string test, input string what, input logic exp,
                              input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s %s: expected %b, actual %b", test, what, exp, act);
        end
    endtask

    // --------------------------------------------------
    // Compare process, one pass per run
    // --------------------------------------------------
    initial begin : compare_proc
        expect_t     exp;
        geometry_t   act_geom;
        logic [31:0] ctrl;
        logic [31:0] status;
        logic [31:0] phy_w;
        logic [31:0] rate_w;
        logic [31:0] enc_w;
        logic [31:0] geom_a;
        logic [31:0] geom_b;
        logic [31:0] spare;
        forever begin
            wait (run_pending);
            exp = expected_result(tests[cur]);
            do begin
                reg_read(REG_CTRL, ctrl);   // Busy in bit 0
            end while (ctrl[0]);
            reg_read(REG_STATUS, status);
            reg_read(REG_PHY, phy_w);
            reg_read(REG_RATE, rate_w);
            reg_read(REG_ENCODE, enc_w);
            reg_read(REG_GEOM_A, geom_a);
            reg_read(REG_GEOM_B, geom_b);
            reg_read(8'h1C, spare);         // Unmapped
            act_geom.heads      = geom_a[3:0];
            act_geom.cylinders  = geom_a[31:16];
            act_geom.spt        = geom_b[7:0];
            act_geom.interleave = geom_b[15:8];
            act_geom.skew       = geom_b[23:16];
            check_flag(names[cur], "valid", exp.valid, ctrl[1]);
            check_stage(names[cur], exp.stage, stage_t'(status[3:0]));
            check_flag(names[cur], "unmapped zero", 1'b1, spare == 32'd0);
            // Results only mean something after a full run
            if (exp.valid) begin
                check_flag(names[cur], "differential", exp.is_differential, phy_w[8]);
                check_rate(names[cur], exp.rate, rate_w[2:0]);
                check_encoding(names[cur], exp.encoding, encoding_t'(enc_w[2:0]));
                check_geometry(names[cur], exp.geometry, act_geom);
            end
            run_pending = 1'b0;
        end
    end

    // Hang guard, sized from the test count
    initial begin : watchdog
        wait (tests_built);
        #((RESET_CYCLES + tests.size() * 6 * (STAGE_TIMEOUT + 8)) * CLK_PERIOD);
        $display("Watchdog expired, a discovery run never finished");
        $display("RESULT: FAIL");
        $finish;
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        void'($urandom(32'h1f9e));
        reset       = 1'b1;
        reg_bus     = '0;
        engine_done = '0;
        scen        = '0;
        cur         = 0;
        errors      = 0;
        checks      = 0;
        run_pending = 1'b0;
        add_test("mfm_basic", 2'b01, {3'd2, 1'b1}, {16'd90, 16'd50, 16'd5},
                 {16'd80, 16'd20, 16'd30}, {4'd4, 16'd820, 8'd17, 8'd3, 8'd2, 1'b1}, 4'b0, 1'b0);
        add_test("rll_wins", 2'b01, {3'd2, 1'b1}, {16'd40, 16'd20, 16'd10},
                 {16'd60, 16'd40, 16'd2}, {4'd6, 16'd615, 8'd26, 8'd1, 8'd4, 1'b1}, 4'b0, 1'b0);
        add_test("unknown", 2'b01, {3'd1, 1'b1}, {16'd3, 16'd0, 16'd9},
                 {16'd2, 16'd0, 16'd0}, {4'd2, 16'd306, 8'd17, 8'd2, 8'd0, 1'b1}, 4'b0, 1'b0);
        add_test("esdi_rate", 2'b01, {3'd4, 1'b1}, {16'd50, 16'd30, 16'd1},
                 {16'd5, 16'd1, 16'd7}, {4'd15, 16'd1224, 8'd34, 8'd1, 8'd8, 1'b1}, 4'b0, 1'b0);
        add_test("esdi_diff", 2'b11, {3'd2, 1'b1}, {16'd50, 16'd30, 16'd1},
                 {16'd5, 16'd1, 16'd7}, {4'd8, 16'd1024, 8'd36, 8'd1, 8'd3, 1'b1}, 4'b0, 1'b0);
        add_test("defaults", 2'b01, {3'd6, 1'b0}, {16'd10, 16'd7, 16'd1},
                 {16'd10, 16'd2, 16'd5}, {4'd9, 16'd999, 8'd40, 8'd5, 8'd5, 1'b0}, 4'b0, 1'b0);
        add_test("no_signal", 2'b00, {3'd2, 1'b1}, {16'd10, 16'd7, 16'd1},
                 {16'd10, 16'd2, 16'd5}, {4'd4, 16'd820, 8'd17, 8'd3, 8'd2, 1'b1}, 4'b0, 1'b0);
        add_test("abort", 2'b01, {3'd2, 1'b1}, {16'd10, 16'd7, 16'd1},
                 {16'd10, 16'd2, 16'd5}, {4'd4, 16'd820, 8'd17, 8'd3, 8'd2, 1'b1}, 4'b1000, 1'b1);
        add_test("timeout", 2'b01, {3'd2, 1'b1}, {16'd10, 16'd7, 16'd1},
                 {16'd10, 16'd2, 16'd5}, {4'd5, 16'd733, 8'd25, 8'd2, 8'd1, 1'b1}, 4'b0001, 1'b0);
        for (int r = 0; r < 3; r++) begin
            add_test($sformatf("random_%0d", r), {1'($urandom % 2), 1'b1},
                     {3'($urandom % 4), 1'($urandom % 2)},
                     {16'($urandom % 256), 16'($urandom % 64), 16'($urandom % 64)},
                     {16'($urandom % 256), 16'($urandom % 64), 16'($urandom % 64)},
                     45'({$urandom, $urandom}), 4'b0, 1'b0);
        end
        tests_built = 1'b1;
        for (int i = 0; i < 4; i++) begin
            automatic int idx = i;
            fork
                engine_model(idx);
            join_none
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        reset = 1'b0;
        for (int i = 0; i < tests.size(); i++) begin
            scen = tests[i];
            cur  = i;
            reg_write(REG_CTRL, 32'h1);   // Start
            if (scen.abort) begin
                repeat (6) @(posedge clk);     // Well inside the silent PHY wait
                reg_write(REG_CTRL, 32'h2);
            end
            run_pending = 1'b1;
            wait (!run_pending);
        end
        // Sequencer assertion failures count as errors too
        errors += hdd_discovery_inst.sequencer_inst.sequencer_sva_inst.failures;
        $display("Errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: verif/discovery_sequencer_sva.sv
`timescale 1ns/1ps

module discovery_sequencer_sva (
    input logic                             clk,
    input logic                             reset,
    input logic                             busy,
    input hdd_discovery_pkg::engine_start_t engine_start
);
    import hdd_discovery_pkg::*;

    logic [3:0] pulses;         // Start pulses without the use_mfm level
    int         failures = 0;   // Failed assertion count

    assign pulses = {engine_start.phy, engine_start.rate, engine_start.decode,
                     engine_start.geometry};

    // --------------------------------------------------
    // Engine start pulses
    // --------------------------------------------------
    start_one_cycle: assert property (@(posedge clk) disable iff (reset)
        (pulses != 4'd0) |=> (pulses == 4'd0))
    else begin
        $error("engine start held past one cycle");
        failures++;
    end

    start_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(pulses))
    else begin
        $error("several engine starts at once");
        failures++;
    end

    no_start_idle: assert property (@(posedge clk) disable iff (reset)
        !busy |-> (pulses == 4'd0))
    else begin
        $error("engine start while idle");
        failures++;
    end

    busy_after_reset: assert property (@(posedge clk)
        reset |=> !busy)
    else begin
        $error("busy high after reset");
        failures++;
    end

endmodule

bind discovery_sequencer discovery_sequencer_sva sequencer_sva_inst (
    .clk          (clk),
    .reset        (reset),
    .busy         (busy),
    .engine_start (engine_start)
);

// File: rtl/hdd_discovery.sv
`timescale 1ns/1ps

module hdd_discovery #(
    parameter int STAGE_TIMEOUT_CYCLES = 4096
) (
    input  logic                                clk,
    input  logic                                reset,
    input  hdd_discovery_pkg::reg_bus_t         reg_bus,
    output logic [31:0]                         rd_data,
    output hdd_discovery_pkg::engine_start_t    engine_start,
    input  hdd_discovery_pkg::engine_done_t     engine_done,
    input  hdd_discovery_pkg::phy_report_t      phy_report,
    input  hdd_discovery_pkg::rate_report_t     rate_report,
    input  hdd_discovery_pkg::decode_counts_t   decode_counts,
    input  hdd_discovery_pkg::geometry_report_t geometry_report
);
    import hdd_discovery_pkg::*;

    logic       start_pulse;
    logic       abort_pulse;
    logic       busy;
    logic       run_start;
    logic       valid;
    logic       is_differential;
    logic [2:0] rate;
    stage_t     stage;
    capture_t   capture;
    encoding_t  encoding;
    geometry_t  geometry;

    // --------------------------------------------------
    // CPU side
    // --------------------------------------------------
    discovery_registers registers_inst (
        .clk             (clk),
        .reset           (reset),
        .reg_bus         (reg_bus),
        .rd_data         (rd_data),
        .start_pulse     (start_pulse),
        .abort_pulse     (abort_pulse),
        .busy            (busy),
        .stage           (stage),
        .valid           (valid),
        .encoding        (encoding),
        .is_differential (is_differential),
        .rate            (rate),
        .geometry        (geometry)
    );

    // --------------------------------------------------
    // Stage control and result capture
    // --------------------------------------------------
    discovery_sequencer #(
        .STAGE_TIMEOUT_CYCLES (STAGE_TIMEOUT_CYCLES)
    ) sequencer_inst (
        .clk            (clk),
        .reset          (reset),
        .start_pulse    (start_pulse),
        .abort_pulse    (abort_pulse),
        .engine_done    (engine_done),
        .signal_present (phy_report.signal_present),
        .busy           (busy),
        .stage          (stage),
        .engine_start   (engine_start),
        .capture        (capture),
        .run_start      (run_start)
    );

    encoding_classifier classifier_inst (
        .clk             (clk),
        .reset           (reset),
        .capture         (capture),
        .decode_counts   (decode_counts),
        .rate            (rate),              // Latched, after fallback
        .is_differential (is_differential),
        .encoding        (encoding)
    );

    discovery_results results_inst (
        .clk             (clk),
        .reset           (reset),
        .capture         (capture),
        .run_start       (run_start),
        .phy_report      (phy_report),
        .rate_report     (rate_report),
        .geometry_report (geometry_report),
        .is_differential (is_differential),
        .rate            (rate),
        .geometry        (geometry),
        .valid           (valid)
    );

endmodule

// File: rtl/discovery_registers.sv
`timescale 1ns/1ps

module discovery_registers (
    input  logic                         clk,
    input  logic                         reset,
    input  hdd_discovery_pkg::reg_bus_t  reg_bus,
    output logic [31:0]                  rd_data,
    output logic                         start_pulse,
    output logic                         abort_pulse,
    input  logic                         busy,
    input  hdd_discovery_pkg::stage_t    stage,
    input  logic                         valid,
    input  hdd_discovery_pkg::encoding_t encoding,
    input  logic                         is_differential,
    input  logic [2:0]                   rate,
    input  hdd_discovery_pkg::geometry_t geometry
);
    import hdd_discovery_pkg::*;

    logic        ctrl_write;   // Write hits CTRL
    logic [31:0] read_word;    // Word for the addressed register

    assign ctrl_write = reg_bus.wr_en && (reg_bus.addr == REG_CTRL);

    // --------------------------------------------------
    // Read mux
    // --------------------------------------------------
    always_comb begin
        case (reg_bus.addr)
            REG_CTRL:   read_word = {30'd0, valid, busy};
            REG_STATUS: read_word = {28'd0, stage};
            REG_PHY:    read_word = {23'd0, is_differential, 8'd0};
            REG_RATE:   read_word = {29'd0, rate};
            REG_ENCODE: read_word = {29'd0, encoding};
            REG_GEOM_A: read_word = {geometry.cylinders, 12'd0, geometry.heads};
            REG_GEOM_B: begin
                read_word = {8'd0, geometry.skew, geometry.interleave, geometry.spt};
            end
            default:    read_word = 32'd0;   // Unmapped
        endcase
    end

    // Control pulses and registered read data
    always_ff @(posedge clk) begin
        if (reset) begin
            start_pulse <= 1'b0;
            abort_pulse <= 1'b0;
            rd_data     <= 32'd0;
        end else begin
            start_pulse <= ctrl_write && reg_bus.wr_data[0];
            abort_pulse <= ctrl_write && reg_bus.wr_data[1];
            if (reg_bus.rd_en) begin
                rd_data <= read_word;   // Holds between reads
            end
        end
    end

endmodule

// File: rtl/discovery_results.sv
`timescale 1ns/1ps

module discovery_results (
    input  logic                                clk,
    input  logic                                reset,
    input  hdd_discovery_pkg::capture_t         capture,
    input  logic                                run_start,
    input  hdd_discovery_pkg::phy_report_t      phy_report,
    input  hdd_discovery_pkg::rate_report_t     rate_report,
    input  hdd_discovery_pkg::geometry_report_t geometry_report,
    output logic                                is_differential,
    output logic [2:0]                          rate,
    output hdd_discovery_pkg::geometry_t        geometry,
    output logic                                valid
);
    import hdd_discovery_pkg::*;

    // --------------------------------------------------
    // Engine results with fallbacks
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            is_differential <= 1'b0;
            rate            <= '0;
            geometry        <= '0;
        end else begin
            if (capture.phy) begin
                is_differential <= phy_report.is_differential;
            end
            if (capture.rate) begin
                // Unknown rate, assume the slowest
                rate <= rate_report.valid ? rate_report.rate : DEFAULT_RATE;
            end
            if (capture.geometry) begin
                geometry <= geometry_report.valid ? geometry_report.geometry
                                                  : DEFAULT_GEOMETRY;
            end
        end
    end

    // Valid only after a run reached the geometry capture
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (run_start) begin
            valid <= 1'b0;
        end else if (capture.geometry) begin
            valid <= 1'b1;
        end
    end

endmodule

// File: rtl/encoding_classifier.sv
`timescale 1ns/1ps

module encoding_classifier (
    input  logic                              clk,
    input  logic                              reset,
    input  hdd_discovery_pkg::capture_t       capture,
    input  hdd_discovery_pkg::decode_counts_t decode_counts,
    input  logic [2:0]                        rate,
    input  logic                              is_differential,
    output hdd_discovery_pkg::encoding_t      encoding
);
    import hdd_discovery_pkg::*;

    decode_counts_t mfm_counts;   // MFM trial result
    decode_counts_t rll_counts;   // RLL trial result
    logic           rll_better;   // More good CRCs and fewer errors

    assign rll_better = (rll_counts.crc_ok > mfm_counts.crc_ok) &&
                        (rll_counts.errors < mfm_counts.errors);

    // Trial counts, one register per trial
    always_ff @(posedge clk) begin
        if (capture.mfm) begin
            mfm_counts <= decode_counts;
        end
        if (capture.rll) begin
            rll_counts <= decode_counts;
        end
    end

    // --------------------------------------------------
    // Decision, rules in priority order
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            encoding <= ENC_UNKNOWN;
        end else if (capture.classify) begin
            if (rate >= ESDI_MIN_RATE || is_differential) begin
                encoding <= ENC_ESDI;      // Fast or differential link
            end else if (rll_better) begin
                encoding <= ENC_RLL;
            end else if (mfm_counts.crc_ok != 16'd0) begin
                encoding <= ENC_MFM;
            end else begin
                encoding <= ENC_UNKNOWN;   // Neither trial decoded
            end
        end
    end

endmodule

// File: rtl/discovery_sequencer.sv
`timescale 1ns/1ps

module discovery_sequencer #(
    parameter int STAGE_TIMEOUT_CYCLES = 4096   // Wait limit per engine stage
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             start_pulse,
    input  logic                             abort_pulse,
    input  hdd_discovery_pkg::engine_done_t  engine_done,
    input  logic                             signal_present,
    output logic                             busy,
    output hdd_discovery_pkg::stage_t        stage,
    output hdd_discovery_pkg::engine_start_t engine_start,
    output hdd_discovery_pkg::capture_t      capture,
    output logic                             run_start
);
    import hdd_discovery_pkg::*;

    localparam int               CNT_W     = $clog2(STAGE_TIMEOUT_CYCLES + 1);
    localparam logic [CNT_W-1:0] LAST_WAIT = CNT_W'(STAGE_TIMEOUT_CYCLES - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_START,     // Pulse the engine start
        S_WAIT,      // Done, abort or timeout
        S_CAPTURE,   // Capture strobe is high here
        S_NEXT,      // Advance the stage
        S_DONE       // Drop busy
    } seq_state_t;

    seq_state_t       state;
    logic [CNT_W-1:0] wait_count;      // Cycles spent in this wait
    logic             stage_done;      // Done strobe of the current engine
    capture_t         stage_capture;   // Capture strobe of the current stage
    stage_t           next_stage;

    // --------------------------------------------------
    // Per stage routing
    // --------------------------------------------------
    always_comb begin
        stage_done    = 1'b0;
        stage_capture = '0;
        next_stage    = STAGE_COMPLETE;
        case (stage)
            STAGE_PHY_PROBE: begin
                stage_done        = engine_done.phy;
                stage_capture.phy = 1'b1;
                // Dead channel ends the run here
                next_stage        = signal_present ? STAGE_RATE_DETECT : STAGE_ERROR;
            end
            STAGE_RATE_DETECT: begin
                stage_done         = engine_done.rate;
                stage_capture.rate = 1'b1;
                next_stage         = STAGE_DECODE_MFM;
            end
            STAGE_DECODE_MFM: begin
                stage_done        = engine_done.decode;
                stage_capture.mfm = 1'b1;
                next_stage        = STAGE_DECODE_RLL;
            end
            STAGE_DECODE_RLL: begin
                stage_done        = engine_done.decode;
                stage_capture.rll = 1'b1;
                next_stage        = STAGE_CLASSIFY;
            end
            STAGE_CLASSIFY: begin
                stage_capture.classify = 1'b1;
                next_stage             = STAGE_GEOMETRY;
            end
            STAGE_GEOMETRY: begin
                stage_done             = engine_done.geometry;
                stage_capture.geometry = 1'b1;
                next_stage             = STAGE_COMPLETE;
            end
            default: ;
        endcase
    end

    // --------------------------------------------------
    // Stage FSM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= S_IDLE;
            stage        <= STAGE_IDLE;
            busy         <= 1'b0;
            run_start    <= 1'b0;
            engine_start <= '0;
            capture      <= '0;
            wait_count   <= '0;
        end else begin
            // Strobes default low, use_mfm keeps its level
            run_start             <= 1'b0;
            capture               <= '0;
            engine_start.phy      <= 1'b0;
            engine_start.rate     <= 1'b0;
            engine_start.decode   <= 1'b0;
            engine_start.geometry <= 1'b0;

            case (state)
                S_IDLE: begin
                    if (start_pulse) begin
                        busy      <= 1'b1;
                        run_start <= 1'b1;   // Clears valid downstream
                        stage     <= STAGE_PHY_PROBE;
                        state     <= S_START;
                    end
                end
                S_START: begin
                    wait_count <= '0;
                    state      <= S_WAIT;
                    case (stage)
                        STAGE_PHY_PROBE:   engine_start.phy  <= 1'b1;
                        STAGE_RATE_DETECT: engine_start.rate <= 1'b1;
                        STAGE_DECODE_MFM: begin
                            engine_start.decode  <= 1'b1;
                            engine_start.use_mfm <= 1'b1;
                        end
                        STAGE_DECODE_RLL: begin
                            engine_start.decode  <= 1'b1;
                            engine_start.use_mfm <= 1'b0;
                        end
                        STAGE_GEOMETRY:    engine_start.geometry <= 1'b1;
                        STAGE_CLASSIFY: begin
                            capture <= stage_capture;   // Straight to capture
                            state   <= S_CAPTURE;
                        end
                        default: state <= S_DONE;   // Final stage, nothing to run
                    endcase
                end
                S_WAIT: begin
                    wait_count <= wait_count + 1'b1;
                    if (abort_pulse) begin
                        stage <= STAGE_ERROR;
                        state <= S_DONE;
                    end else if (stage_done || wait_count == LAST_WAIT) begin
                        // Timeout keeps whatever the engine shows
                        capture <= stage_capture;
                        state   <= S_CAPTURE;
                    end
                end
                S_CAPTURE: begin
                    if (next_stage == STAGE_COMPLETE || next_stage == STAGE_ERROR) begin
                        stage <= next_stage;
                        state <= S_DONE;
                    end else begin
                        state <= S_NEXT;
                    end
                end
                S_NEXT: begin
                    stage <= next_stage;
                    state <= S_START;
                end
                S_DONE: begin
                    busy  <= 1'b0;   // Stage keeps the final code
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/hdd_discovery_pkg.sv
package hdd_discovery_pkg;

    // --------------------------------------------------
    // Stage and encoding codes
    // --------------------------------------------------
    // Run stages, reported in STATUS[3:0]
    typedef enum logic [3:0] {
        STAGE_IDLE        = 4'd0,
        STAGE_PHY_PROBE   = 4'd1,
        STAGE_RATE_DETECT = 4'd2,
        STAGE_DECODE_MFM  = 4'd3,   // First decode trial
        STAGE_DECODE_RLL  = 4'd4,   // Second decode trial
        STAGE_CLASSIFY    = 4'd5,   // No engine
        STAGE_GEOMETRY    = 4'd6,
        STAGE_COMPLETE    = 4'd7,
        STAGE_ERROR       = 4'd8    // No signal or abort
    } stage_t;

    typedef enum logic [2:0] {
        ENC_UNKNOWN = 3'd0,
        ENC_MFM     = 3'd1,
        ENC_RLL     = 3'd2,
        ENC_ESDI    = 3'd3
    } encoding_t;

    // --------------------------------------------------
    // Engine reports
    // --------------------------------------------------
    typedef struct packed {
        logic is_differential;
        logic signal_present;   // Any activity on the read channel
    } phy_report_t;

    typedef struct packed {
        logic [2:0] rate;       // Rate code
        logic       valid;
    } rate_report_t;

    // One decode trial
    typedef struct packed {
        logic [15:0] sync_hits;
        logic [15:0] crc_ok;
        logic [15:0] errors;
    } decode_counts_t;

    typedef struct packed {
        logic [3:0]  heads;
        logic [15:0] cylinders;
        logic [7:0]  spt;          // Sectors per track
        logic [7:0]  interleave;
        logic [7:0]  skew;         // Track to track offset
    } geometry_t;

    typedef struct packed {
        geometry_t geometry;
        logic      valid;
    } geometry_report_t;

    // --------------------------------------------------
    // Sequencer strobes
    // --------------------------------------------------
    typedef struct packed {
        logic phy;
        logic rate;
        logic decode;
        logic geometry;
        logic use_mfm;      // Level, selects the decode trial
    } engine_start_t;

    typedef struct packed {
        logic phy;
        logic rate;
        logic decode;
        logic geometry;
    } engine_done_t;

    typedef struct packed {
        logic phy;
        logic rate;
        logic mfm;
        logic rll;
        logic classify;
        logic geometry;     // Also sets the result valid flag
    } capture_t;

    // CPU register port
    typedef struct packed {
        logic [7:0]  addr;
        logic        wr_en;
        logic        rd_en;
        logic [31:0] wr_data;
    } reg_bus_t;

    // --------------------------------------------------
    // Register map and defaults
    // --------------------------------------------------
    localparam logic [7:0] REG_CTRL   = 8'h00;
    localparam logic [7:0] REG_STATUS = 8'h04;
    localparam logic [7:0] REG_PHY    = 8'h08;
    localparam logic [7:0] REG_RATE   = 8'h0C;
    localparam logic [7:0] REG_ENCODE = 8'h10;
    localparam logic [7:0] REG_GEOM_A = 8'h14;
    localparam logic [7:0] REG_GEOM_B = 8'h18;

    localparam logic [2:0] DEFAULT_RATE  = 3'd1;   // Slowest rate
    localparam logic [2:0] ESDI_MIN_RATE = 3'd3;   // At or above means ESDI

    // Small classic drive, 2 heads x 615 cyl x 17 spt
    localparam geometry_t DEFAULT_GEOMETRY = '{
        heads:      4'd2,
        cylinders:  16'd615,
        spt:        8'd17,
        interleave: 8'd1,
        skew:       8'd0
    };

endpackage
